//--- Makefile
# Verilator build and run of the vector ALU testbench
# Any variable can be overridden, for example: make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= valu_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides the result, a missing pass line also fails
run: compile
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi; \
	if ! grep -q '>>> PASS' $(LOG); then echo "simulation ended early, status $$status"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src.f
+incdir+.
valu_pkg.sv
valu_simd_alu.sv
valu_insn_queue.sv
valu_issue_seq.sv
valu_result_queue.sv
valu_top.sv
tb_clk_gen.sv
valu_tb.sv

//--- tb_clk_gen.sv
// Testbench clock and reset source
// Free running clock, active low reset held for a number of cycles

module tb_clk_gen #(
  parameter int unsigned period_ns  = 8,
  parameter int unsigned rst_cycles = 5
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (rst_cycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- valu_config.svh
// Vector ALU build configuration
// Depths and widths shared by the package and every RTL block

`ifndef VALU_CONFIG_SVH
`define VALU_CONFIG_SVH

// Datapath word and its byte strobes
`define VALU_DATA_W 64
`define VALU_STRB_W 8

// Queue depths
`define VALU_INSN_DEPTH 4
`define VALU_RES_DEPTH 2

// Vector length in elements, register file word address
`define VALU_VL_W 8
`define VALU_ADDR_W 10

// Instruction ids in flight, one done bit each
`define VALU_NR_INSN 8
`define VALU_ID_W 3

`endif

//--- valu_insn_queue.sv
// Vector ALU instruction queue
// Ring of in-flight instructions with accept, issue and commit pointers.
// Hands the issue head to the sequencer, counts granted elements of the
// commit head and pulses its done bit on the grant of the last word

`include "valu_config.svh"

module valu_insn_queue import valu_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  vinsn_t                   insn_i,
  input  logic                     insn_valid_i,
  output logic                     insn_ready_o,
  output vinsn_t                   issue_insn_o,
  output logic                     issue_valid_o,
  input  logic                     issue_last_i,
  input  logic                     res_gnt_i,
  output logic [`VALU_NR_INSN-1:0] insn_done_o
);

  localparam int unsigned depth = `VALU_INSN_DEPTH;
  localparam int unsigned pnt_w = $clog2(depth);

  typedef logic [pnt_w-1:0] pnt_t;
  typedef logic [pnt_w:0]   cnt_t;

  // Wrap a ring pointer at the queue depth
  function automatic pnt_t next_pnt(pnt_t pnt);
    next_pnt = (pnt == pnt_t'(depth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  vinsn_t ring_q [depth];
  pnt_t   accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Entries waiting to issue, entries not yet committed
  cnt_t   issue_cnt_q, commit_cnt_q;
  // Elements of the commit head still to be written back
  vlen_t  commit_rem_q;
  logic   commit_armed_q;

  logic   accept;
  logic   commit_last;
  vinsn_t commit_vinsn;
  logic [3:0] commit_epw;
  vlen_t  commit_rem;

  assign insn_ready_o = (commit_cnt_q != cnt_t'(depth));
  assign accept       = insn_valid_i && insn_ready_o;

  assign issue_insn_o  = ring_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  // Commit head counter loads from vl on its first grant
  assign commit_vinsn = ring_q[commit_pnt_q];
  assign commit_epw   = 4'd8 >> commit_vinsn.vsew;
  assign commit_rem   = commit_armed_q ? commit_rem_q : commit_vinsn.vl;
  assign commit_last  = res_gnt_i && (commit_cnt_q != '0) &&
                        (commit_rem <= vlen_t'(commit_epw));

  // Done pulse in the grant cycle of the last word
  always_comb begin
    insn_done_o = '0;
    if (commit_last) begin
      insn_done_o[commit_vinsn.id] = 1'b1;
    end
  end

  // Instruction storage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      ring_q[accept_pnt_q] <= insn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q   <= '0;
      issue_pnt_q    <= '0;
      commit_pnt_q   <= '0;
      issue_cnt_q    <= '0;
      commit_cnt_q   <= '0;
      commit_rem_q   <= '0;
      commit_armed_q <= 1'b0;
    end else begin
      if (accept) begin
        accept_pnt_q <= next_pnt(accept_pnt_q);
      end
      if (issue_last_i) begin
        issue_pnt_q <= next_pnt(issue_pnt_q);
      end
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_last_i);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_last);
      // Next head starts unarmed and reloads from its own vl
      if (commit_last) begin
        commit_pnt_q   <= next_pnt(commit_pnt_q);
        commit_armed_q <= 1'b0;
      end else if (res_gnt_i) begin
        commit_rem_q   <= commit_rem - vlen_t'(commit_epw);
        commit_armed_q <= 1'b1;
      end
    end
  end

  // Every grant belongs to a word of an uncommitted instruction
  a_gnt_has_head: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_gnt_i |-> (commit_cnt_q != '0));

  // Sequencer only finishes an instruction it was handed
  a_last_has_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_last_i |-> issue_valid_o);

endmodule

//--- valu_issue_seq.sv
// Issue sequencer of the vector ALU
// Walks the issue head word by word, waits for its operands and mask,
// replicates the scalar operand, and pushes each computed word with
// its address and byte enables into the result queue

`include "valu_config.svh"

module valu_issue_seq import valu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  vinsn_t  issue_insn_i,
  input  logic    issue_valid_i,
  output logic    issue_last_o,
  input  elen_t   operand_a_i,
  input  elen_t   operand_b_i,
  input  logic    operand_a_valid_i,
  input  logic    operand_b_valid_i,
  output logic    operand_a_ready_o,
  output logic    operand_b_ready_o,
  input  strb_t   mask_i,
  input  logic    mask_valid_i,
  output logic    mask_ready_o,
  input  logic    res_full_i,
  output logic    res_push_o,
  output result_t res_data_o
);

  // Remaining elements and words already issued, valid once armed
  vlen_t  rem_q;
  vaddr_t word_q;
  logic   armed_q;

  vlen_t      rem;
  vaddr_t     word;
  logic [3:0] epw;
  logic       issue;
  elen_t      scalar_rep;
  elen_t      alu_a;
  elen_t      alu_res;
  strb_t      be;

  // Fresh instruction takes its counts straight from vl
  assign rem  = armed_q ? rem_q : issue_insn_i.vl;
  assign word = armed_q ? word_q : '0;
  assign epw  = 4'd8 >> issue_insn_i.vsew;

  ////////////////////////////////////////////////////////////////////////////
  // Operands

  always_comb begin
    unique case (issue_insn_i.vsew)
      EW8:     scalar_rep = {8{issue_insn_i.scalar[7:0]}};
      EW16:    scalar_rep = {4{issue_insn_i.scalar[15:0]}};
      EW32:    scalar_rep = {2{issue_insn_i.scalar[31:0]}};
      default: scalar_rep = issue_insn_i.scalar;
    endcase
  end

  assign alu_a = issue_insn_i.use_scalar ? scalar_rep : operand_a_i;

  valu_simd_alu i_simd_alu (
    .operand_a_i (alu_a),
    .operand_b_i (operand_b_i),
    .op_i        (issue_insn_i.op),
    .vsew_i      (issue_insn_i.vsew),
    .result_o    (alu_res)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Issue and write-back payload

  assign issue = issue_valid_i && !res_full_i && operand_b_valid_i &&
                 (operand_a_valid_i || issue_insn_i.use_scalar) &&
                 (mask_valid_i || issue_insn_i.vm);

  assign issue_last_o      = issue && (rem <= vlen_t'(epw));
  assign operand_b_ready_o = issue;
  assign operand_a_ready_o = issue && !issue_insn_i.use_scalar;
  assign mask_ready_o      = issue && !issue_insn_i.vm;

  // Tail elements off, masked bytes off unless unmasked
  always_comb begin
    for (int b = 0; b < `VALU_STRB_W; b++) begin
      be[b] = (vlen_t'(b >> issue_insn_i.vsew) < rem) &&
              (issue_insn_i.vm || mask_i[b]);
    end
  end

  assign res_push_o       = issue;
  assign res_data_o.id    = issue_insn_i.id;
  assign res_data_o.addr  = issue_insn_i.vd + word;
  assign res_data_o.wdata = alu_res;
  assign res_data_o.be    = be;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q   <= '0;
      word_q  <= '0;
      armed_q <= 1'b0;
    end else if (issue) begin
      // Last word disarms, the next head loads its own vl
      armed_q <= !issue_last_o;
      rem_q   <= rem - vlen_t'(epw);
      word_q  <= word + 1'b1;
    end
  end

endmodule

//--- valu_pkg.sv
// Vector ALU types
// Element widths, opcodes, instruction and register file write formats

`include "valu_config.svh"

package valu_pkg;

  // Element width, also the shift that gives elements per word
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } ew_e;

  // Integer operations of the lane ALU
  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VXOR,
    VMIN,
    VMINU,
    VMAX
  } alu_op_e;

  typedef logic [`VALU_DATA_W-1:0] elen_t;
  typedef logic [`VALU_STRB_W-1:0] strb_t;
  typedef logic [`VALU_VL_W-1:0]   vlen_t;
  typedef logic [`VALU_ADDR_W-1:0] vaddr_t;
  typedef logic [`VALU_ID_W-1:0]   vid_t;

  // One vector instruction as handed over by the lane sequencer
  typedef struct packed {
    alu_op_e op;
    ew_e     vsew;
    vlen_t   vl;
    vaddr_t  vd;          // base word address of the destination
    vid_t    id;
    logic    vm;          // unmasked when set
    logic    use_scalar;  // scalar replaces vector source 1
    elen_t   scalar;
  } vinsn_t;

  // One register file write
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_t;

endpackage

//--- valu_result_queue.sv
// Result queue of the vector ALU
// Small circular buffer between the sequencer and the register file.
// The head entry is requested until granted, then popped

`include "valu_config.svh"

module valu_result_queue import valu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    push_i,
  input  result_t data_i,
  output logic    full_o,
  output logic    result_req_o,
  output result_t result_o,
  input  logic    result_gnt_i
);

  localparam int unsigned depth = `VALU_RES_DEPTH;
  localparam int unsigned pnt_w = (depth > 1) ? $clog2(depth) : 1;

  typedef logic [pnt_w-1:0] pnt_t;

  result_t mem_q [depth];
  pnt_t    wr_pnt_q, rd_pnt_q;
  logic [pnt_w:0] cnt_q;
  logic    pop;

  assign full_o       = (cnt_q == depth);
  assign result_req_o = (cnt_q != '0);
  // Head stays put until granted, so the payload is stable
  assign result_o     = mem_q[rd_pnt_q];
  assign pop          = result_gnt_i && result_req_o;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_pnt_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_pnt_q <= (wr_pnt_q == pnt_t'(depth - 1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= (rd_pnt_q == pnt_t'(depth - 1)) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + (pnt_w + 1)'(push_i) - (pnt_w + 1)'(pop);
    end
  end

  // Sequencer must respect full
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

  // Instruction queue counts raw grants, so none may come unrequested
  a_no_gnt_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_gnt_i |-> result_req_o);

endmodule

//--- valu_simd_alu.sv
// SIMD integer datapath of the vector ALU
// Works on one 64-bit word as 8, 4, 2 or 1 independent elements.
// Purely combinational, one result per element width, picked by vsew

`include "valu_config.svh"

module valu_simd_alu import valu_pkg::*; (
  input  elen_t   operand_a_i,
  input  elen_t   operand_b_i,
  input  alu_op_e op_i,
  input  ew_e     vsew_i,
  output elen_t   result_o
);

  // Word result for every element width
  elen_t res_w [4];

  for (genvar w = 0; w < 4; w++) begin : gen_width
    localparam int unsigned ew_bits = 8 << w;
    localparam int unsigned lanes   = `VALU_STRB_W >> w;

    for (genvar l = 0; l < lanes; l++) begin : gen_lane
      logic [ew_bits-1:0] a, b, r;
      logic               lt_u, lt_s;

      // Operand a is vector source 1, operand b is vector source 2
      assign a = operand_a_i[l*ew_bits +: ew_bits];
      assign b = operand_b_i[l*ew_bits +: ew_bits];

      always_comb begin
        lt_u = (a < b);
        // Differing top bits decide the signed order on their own
        lt_s = (a[ew_bits-1] != b[ew_bits-1]) ? a[ew_bits-1] : lt_u;

        unique case (op_i)
          VADD:    r = b + a;
          VSUB:    r = b - a;   // vs2 - vs1, wraps within the element
          VAND:    r = b & a;
          VOR:     r = b | a;
          VXOR:    r = b ^ a;
          VMIN:    r = lt_s ? a : b;
          VMINU:   r = lt_u ? a : b;
          VMAX:    r = lt_s ? b : a;
          default: r = '0;
        endcase
      end

      assign res_w[w][l*ew_bits +: ew_bits] = r;
    end
  end

  assign result_o = res_w[vsew_i];

endmodule

//--- valu_tb.sv
// Testbench of the vector lane ALU
// Applies a table of instructions, feeds random operands and masks,
// withholds register file grants at random and checks every write
// against a reference model of the element-wise rules

`include "valu_config.svh"

module valu_tb import valu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic clk, rst_n;
  vinsn_t insn_i;
  logic insn_valid_i, insn_ready_o;
  logic [`VALU_NR_INSN-1:0] insn_done_o;
  elen_t operand_a_i, operand_b_i;
  logic operand_a_valid_i, operand_a_ready_o, operand_b_valid_i, operand_b_ready_o;
  strb_t mask_i;
  logic mask_valid_i, mask_ready_o;
  logic result_req_o, result_gnt_i;
  result_t result_o;

  // Stimulus table, one instruction per row
  string t_name [64];
  alu_op_e t_op [64];
  ew_e t_sew [64];
  int t_vl [64];
  bit t_vm [64];
  bit t_scal [64];
  elen_t t_scalar [64];
  int t_gnt [64];
  int nrows, total_words, errors, tests_run, tests_failed, gnt_pct;
  bit table_ready, hold_ops, held_valid;
  string cur_name;
  result_t held;

  // Offered stimulus and expected writes, in order
  vinsn_t ins_q [$];
  elen_t a_q [$];
  elen_t b_q [$];
  strb_t m_q [$];
  result_t exp_q [$];
  bit last_q [$];

  tb_clk_gen #(.period_ns(8), .rst_cycles(5)) i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  valu_top i_dut (
    .clk_i (clk), .rst_ni (rst_n),
    .insn_i (insn_i), .insn_valid_i (insn_valid_i), .insn_ready_o (insn_ready_o),
    .insn_done_o (insn_done_o),
    .operand_a_i (operand_a_i), .operand_a_valid_i (operand_a_valid_i),
    .operand_a_ready_o (operand_a_ready_o),
    .operand_b_i (operand_b_i), .operand_b_valid_i (operand_b_valid_i),
    .operand_b_ready_o (operand_b_ready_o),
    .mask_i (mask_i), .mask_valid_i (mask_valid_i), .mask_ready_o (mask_ready_o),
    .result_req_o (result_req_o), .result_o (result_o), .result_gnt_i (result_gnt_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model

  function automatic elen_t elem_mask(ew_e sew);
    return (sew == EW64) ? '1 : (64'd1 << (8 << sew)) - 64'd1;
  endfunction

  // Scalar copied into every element
  function automatic elen_t replicate(elen_t s, ew_e sew);
    elen_t r;
    r = '0;
    for (int e = 0; e < (8 >> sew); e++) r |= (s & elem_mask(sew)) << (e * (8 << sew));
    return r;
  endfunction

  // vs1 is a, vs2 is b, results wrap inside the element
  function automatic elen_t model_alu(alu_op_e op, ew_e sew, elen_t a, elen_t b);
    int ewb;
    elen_t x, y, r, res;
    logic signed [63:0] xs, ys;
    ewb = 8 << sew;
    res = '0;
    for (int e = 0; e < (8 >> sew); e++) begin
      x = (a >> (e * ewb)) & elem_mask(sew);
      y = (b >> (e * ewb)) & elem_mask(sew);
      // Sign extend from the element's top bit
      xs = $signed(x << (64 - ewb)) >>> (64 - ewb);
      ys = $signed(y << (64 - ewb)) >>> (64 - ewb);
      case (op)
        VADD:    r = y + x;
        VSUB:    r = y - x;
        VAND:    r = y & x;
        VOR:     r = y | x;
        VXOR:    r = y ^ x;
        VMIN:    r = (xs < ys) ? x : y;
        VMINU:   r = (x < y) ? x : y;
        default: r = (xs > ys) ? x : y;
      endcase
      res |= (r & elem_mask(sew)) << (e * ewb);
    end
    return res;
  endfunction

  // Whole elements below vl are written, masked bytes only if their bit is set
  function automatic strb_t model_be(ew_e sew, int vl, int w, bit vm, strb_t m);
    int n, bpe;
    strb_t be;
    n = 8 >> sew;
    bpe = 1 << sew;
    be = '0;
    for (int e = 0; e < n; e++)
      if (w * n + e < vl)
        for (int k = 0; k < bpe; k++) be[e * bpe + k] = vm || m[e * bpe + k];
    return be;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and checking

  task automatic add_row(string name, alu_op_e op, ew_e sew, int vl, bit vm, bit scal,
                         elen_t scalar, int gnt);
    t_name[nrows] = name;
    t_op[nrows] = op;
    t_sew[nrows] = sew;
    t_vl[nrows] = vl;
    t_vm[nrows] = vm;
    t_scal[nrows] = scal;
    t_scalar[nrows] = scalar;
    t_gnt[nrows] = gnt;
    total_words += (vl + (8 >> sew) - 1) / (8 >> sew);
    nrows++;
  endtask

  task automatic build_table();
    alu_op_e op;
    ew_e sew;
    // Every operation at every width, with a random tail
    for (int o = 0; o < 8; o++) begin
      for (int s = 0; s < 4; s++) begin
        op = alu_op_e'(o);
        sew = ew_e'(s);
        add_row($sformatf("%s_e%0d", op.name(), 8 << s), op, sew,
                2 * (8 >> s) + int'($urandom_range((8 >> s) - 1)), 1'b1, 1'b0, '0, 100);
      end
    end
    add_row("scalar_add_e16", VADD, EW16, 10, 1'b1, 1'b1, 64'h0123_4567_89ab_fedc, 100);
    add_row("scalar_sub_mask_e8", VSUB, EW8, 11, 1'b0, 1'b1, 64'h0000_0000_0000_0080, 100);
    add_row("scalar_max_e64", VMAX, EW64, 3, 1'b1, 1'b1, 64'h8000_0000_0000_0001, 80);
    add_row("tail_minu_e32", VMINU, EW32, 7, 1'b1, 1'b0, '0, 100);
    add_row("mask_add_e32", VADD, EW32, 9, 1'b0, 1'b0, '0, 60);
    add_row("mask_min_e16", VMIN, EW16, 14, 1'b0, 1'b0, '0, 50);
    add_row("stall_xor_e8", VXOR, EW8, 40, 1'b1, 1'b0, '0, 20);
    add_row("stall_max_e16", VMAX, EW16, 22, 1'b0, 1'b0, '0, 30);
    // Rows 0 to 3 run again for the full queue check
    for (int r = 0; r < 4; r++) total_words += (t_vl[r] + (8 >> t_sew[r]) - 1) / (8 >> t_sew[r]);
  endtask

  // Queue one instruction with its operands and expected writes
  task automatic load_test(int r, vid_t id);
    vinsn_t insn;
    result_t exp;
    elen_t a, b, a_eff;
    strb_t m;
    int n, nw;
    n = 8 >> t_sew[r];
    nw = (t_vl[r] + n - 1) / n;
    insn.op = t_op[r];
    insn.vsew = t_sew[r];
    insn.vl = vlen_t'(t_vl[r]);
    insn.vd = vaddr_t'(r * 29 + 5);
    insn.id = id;
    insn.vm = t_vm[r];
    insn.use_scalar = t_scal[r];
    insn.scalar = t_scalar[r];
    ins_q.push_back(insn);
    for (int w = 0; w < nw; w++) begin
      a = {$urandom, $urandom};
      b = {$urandom, $urandom};
      m = strb_t'($urandom);
      if (t_scal[r]) begin
        a_eff = replicate(t_scalar[r], t_sew[r]);
      end else begin
        a_eff = a;
        a_q.push_back(a);
      end
      b_q.push_back(b);
      if (!t_vm[r]) m_q.push_back(m);
      exp.id = id;
      exp.addr = insn.vd + vaddr_t'(w);
      exp.wdata = model_alu(t_op[r], t_sew[r], a_eff, b);
      exp.be = model_be(t_sew[r], t_vl[r], w, t_vm[r], m);
      exp_q.push_back(exp);
      last_q.push_back(w == nw - 1);
    end
  endtask

  task automatic report_value(string what, logic [63:0] exp_v, logic [63:0] act_v);
    errors++;
    $display("error %s %s: expected %h actual %h", cur_name, what, exp_v, act_v);
  endtask

  task automatic report_fail(string msg);
    errors++;
    $display("%s: %s", cur_name, msg);
  endtask

  // Drive on the falling edge and sample 1 ns before the rising edge
  task automatic step();
    result_t exp;
    logic [`VALU_NR_INSN-1:0] exp_done;
    bit last;
    @(negedge clk);
    insn_valid_i = (ins_q.size() != 0);
    if (insn_valid_i) insn_i = ins_q[0];
    operand_a_valid_i = !hold_ops && (a_q.size() != 0) && ($urandom_range(9) != 0);
    if (a_q.size() != 0) operand_a_i = a_q[0];
    operand_b_valid_i = !hold_ops && (b_q.size() != 0) && ($urandom_range(9) != 0);
    if (b_q.size() != 0) operand_b_i = b_q[0];
    mask_valid_i = !hold_ops && (m_q.size() != 0);
    if (m_q.size() != 0) mask_i = m_q[0];
    result_gnt_i = result_req_o && ($urandom_range(99) < gnt_pct);
    #3;
    if (insn_valid_i && insn_ready_o) void'(ins_q.pop_front());
    if (operand_a_ready_o && !operand_a_valid_i) report_fail("operand a taken while not offered");
    else if (operand_a_ready_o) void'(a_q.pop_front());
    if (operand_b_ready_o && !operand_b_valid_i) report_fail("operand b taken while not offered");
    else if (operand_b_ready_o) void'(b_q.pop_front());
    if (mask_ready_o && !mask_valid_i) report_fail("mask taken while not offered");
    else if (mask_ready_o) void'(m_q.pop_front());
    // A waiting request must keep its payload
    if (held_valid && (!result_req_o || result_o !== held)) begin
      report_fail("write changed while waiting");
    end
    exp_done = '0;
    held_valid = 1'b0;
    if (result_req_o && result_gnt_i) begin
      if (exp_q.size() == 0) begin
        report_fail("unexpected register file write");
      end else begin
        exp = exp_q.pop_front();
        last = last_q.pop_front();
        if (result_o.addr !== exp.addr) report_value("addr", exp.addr, result_o.addr);
        if (result_o.id !== exp.id) report_value("id", exp.id, result_o.id);
        if (result_o.wdata !== exp.wdata) report_value("wdata", exp.wdata, result_o.wdata);
        if (result_o.be !== exp.be) report_value("be", exp.be, result_o.be);
        if (last) exp_done[exp.id] = 1'b1;
      end
    end else if (result_req_o) begin
      held = result_o;
      held_valid = 1'b1;
    end
    if (insn_done_o !== exp_done) report_value("done", exp_done, insn_done_o);
  endtask

  // Run until every write is seen, then a few idle cycles for strays
  task automatic drain();
    while (exp_q.size() != 0 || ins_q.size() != 0) step();
    repeat (3) step();
  endtask

  task automatic finish_test(string name, int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %-20s ok", name);
    end else begin
      tests_failed++;
      $display("test %-20s failed with %0d errors", name, errors - err_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    int err0;
    insn_i = '0;
    insn_valid_i = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_a_valid_i = 1'b0;
    operand_b_valid_i = 1'b0;
    mask_i = '0;
    mask_valid_i = 1'b0;
    result_gnt_i = 1'b0;
    void'($urandom(32'h2b4dd7ad));
    build_table();
    table_ready = 1'b1;

    // Idle outputs right after reset
    wait (rst_n);
    @(negedge clk);
    #3;
    cur_name = "reset";
    err0 = errors;
    if (result_req_o !== 1'b0) report_fail("request high after reset");
    if (operand_a_ready_o || operand_b_ready_o || mask_ready_o) begin
      report_fail("ready high after reset");
    end
    if (insn_done_o !== '0) report_fail("done high after reset");
    if (insn_ready_o !== 1'b1) report_fail("instruction queue not ready after reset");
    finish_test(cur_name, err0);

    for (int r = 0; r < nrows; r++) begin
      cur_name = t_name[r];
      gnt_pct = t_gnt[r];
      err0 = errors;
      load_test(r, vid_t'(r));
      drain();
      finish_test(cur_name, err0);
    end

    // Four instructions and no operands fill the instruction queue
    cur_name = "queue_full";
    gnt_pct = 70;
    err0 = errors;
    hold_ops = 1'b1;
    for (int k = 0; k < 4; k++) load_test(k, vid_t'(nrows + k));
    while (ins_q.size() != 0) step();
    step();
    if (insn_ready_o !== 1'b0) report_fail("ready stayed high with four instructions queued");
    hold_ops = 1'b0;
    drain();
    finish_test(cur_name, err0);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Run time bound scaled by the number of words
  initial begin
    wait (table_ready);
    repeat ((total_words + 50) * 20) @(posedge clk);
    $display("timeout, the DUT stopped writing results before all tests finished");
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- valu_top.sv
// Integer lane ALU of the vector processor
// Instruction queue feeds the issue sequencer, which computes one SIMD
// word per cycle into the result queue toward the register file

`include "valu_config.svh"

module valu_top import valu_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Instructions from the lane sequencer
  input  vinsn_t                   insn_i,
  input  logic                     insn_valid_i,
  output logic                     insn_ready_o,
  output logic [`VALU_NR_INSN-1:0] insn_done_o,
  // Operand queues
  input  elen_t                    operand_a_i,
  input  logic                     operand_a_valid_i,
  output logic                     operand_a_ready_o,
  input  elen_t                    operand_b_i,
  input  logic                     operand_b_valid_i,
  output logic                     operand_b_ready_o,
  input  strb_t                    mask_i,
  input  logic                     mask_valid_i,
  output logic                     mask_ready_o,
  // Register file write port
  output logic                     result_req_o,
  output result_t                  result_o,
  input  logic                     result_gnt_i
);

  vinsn_t  issue_insn;
  logic    issue_valid;
  logic    issue_last;
  logic    res_push;
  result_t res_data;
  logic    res_full;

  valu_insn_queue i_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .insn_ready_o  (insn_ready_o),
    .issue_insn_o  (issue_insn),
    .issue_valid_o (issue_valid),
    .issue_last_i  (issue_last),
    .res_gnt_i     (result_gnt_i),
    .insn_done_o   (insn_done_o)
  );

  valu_issue_seq i_issue_seq (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .issue_insn_i      (issue_insn),
    .issue_valid_i     (issue_valid),
    .issue_last_o      (issue_last),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .operand_a_valid_i (operand_a_valid_i),
    .operand_b_valid_i (operand_b_valid_i),
    .operand_a_ready_o (operand_a_ready_o),
    .operand_b_ready_o (operand_b_ready_o),
    .mask_i            (mask_i),
    .mask_valid_i      (mask_valid_i),
    .mask_ready_o      (mask_ready_o),
    .res_full_i        (res_full),
    .res_push_o        (res_push),
    .res_data_o        (res_data)
  );

  valu_result_queue i_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (res_push),
    .data_i       (res_data),
    .full_o       (res_full),
    .result_req_o (result_req_o),
    .result_o     (result_o),
    .result_gnt_i (result_gnt_i)
  );

endmodule
